// ==== src/cache_bus_consts.svh ====
`ifndef CACHE_BUS_CONSTS_SVH
`define CACHE_BUS_CONSTS_SVH

// Line geometry

// 32-bit words per cache line
`define CB_WORDS_PER_LINE 8

// Full line width in bits
`define CB_LINE_BITS 256

// Burst memory

// Depth in 32-bit words
`define CB_MEM_WORDS 1024

// Idle cycles between two word responses, must be at least 1
`define CB_RESP_GAP 1

`endif

// ==== src/cache_bus_pkg.sv ====
`include "cache_bus_consts.svh"

package cache_bus_pkg;

    // One 32-bit byte address, seen either raw or split into line fields
    typedef union packed {
        logic [31:0] raw;               // As driven on the bus
        struct packed {
            logic [26:0] line;          // Line number
            logic [2:0]  word;          // Word inside the line
            logic [1:0]  offset;        // Byte inside the word
        } f;
    } line_addr_u;

    // Word k of a line sits in bits 32k+31 down to 32k
    typedef logic [`CB_LINE_BITS-1:0] line_t;

endpackage

// ==== src/word_bus_if.sv ====
`timescale 1ns/10ps

interface word_bus_if;

    // Read side
    logic        ren;       // Held for the whole burst
    logic [31:0] raddr;
    logic [31:0] rdata;
    logic        rvalid;    // One pulse per word

    // Write side
    logic        wvalid;    // Held for the whole burst
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic        wlast;     // Eighth word of the burst
    logic        wresp;     // Word stored

    // Bridge end
    modport master (
        output ren,
        output raddr,
        input  rdata,
        input  rvalid,
        output wvalid,
        output waddr,
        output wdata,
        output wlast,
        input  wresp
    );

    // Memory end
    modport slave (
        input  ren,
        input  raddr,
        output rdata,
        output rvalid,
        input  wvalid,
        input  waddr,
        input  wdata,
        input  wlast,
        output wresp
    );

endinterface

// ==== src/cache_axi.sv ====
`timescale 1ns/10ps
`include "cache_bus_consts.svh"

module cache_axi
    import cache_bus_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // Instruction cache read port
    input  logic        inst_ren_i,
    input  logic [31:0] inst_araddr_i,
    output logic        inst_rvalid_o,
    output line_t       inst_rdata_o,

    // Data cache read port
    input  logic        data_ren_i,
    input  logic [31:0] data_araddr_i,
    output logic        data_rvalid_o,
    output line_t       data_rdata_o,

    // Data cache write port
    input  logic        data_wen_i,
    input  logic [31:0] data_awaddr_i,
    input  line_t       data_wdata_i,
    output logic        data_bvalid_o,

    word_bus_if.master  bus
);

    localparam logic [2:0] LAST_WORD = 3'(`CB_WORDS_PER_LINE - 1);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DATA,
        RD_INST
    } rd_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_BUSY
    } wr_state_e;

    rd_state_e  rd_state;
    logic [2:0] rd_cnt;             // Word index of the read burst
    line_addr_u rd_addr;            // Latched request address
    line_addr_u rd_bus_addr;
    logic       data_rd_req;
    logic       inst_rd_req;
    logic       rd_done;

    wr_state_e  wr_state;
    logic [2:0] wr_cnt;
    line_addr_u wr_addr;
    line_addr_u wr_bus_addr;
    line_t      wr_line;            // Latched write line
    logic       wr_req;
    logic       wr_done;

    // A port still holds its request during its own return cycle
    assign data_rd_req = data_ren_i && !data_rvalid_o;
    assign inst_rd_req = inst_ren_i && !inst_rvalid_o;
    assign wr_req      = data_wen_i && !data_bvalid_o;

    //////////////////////////////
    // Read channel
    //////////////////////////////

    assign rd_done = (rd_state != RD_IDLE) && bus.rvalid && (rd_cnt == LAST_WORD);

    // Data cache wins a tie
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    rd_cnt <= '0;
                    if (data_rd_req) begin
                        rd_state <= RD_DATA;
                    end else if (inst_rd_req) begin
                        rd_state <= RD_INST;
                    end
                end
                default: begin
                    if (bus.rvalid) begin
                        rd_cnt <= rd_cnt + 3'd1;
                        if (rd_cnt == LAST_WORD) begin
                            rd_state <= RD_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_state == RD_IDLE) begin
            if (data_rd_req) begin
                rd_addr.raw <= data_araddr_i;
            end else if (inst_rd_req) begin
                rd_addr.raw <= inst_araddr_i;
            end
        end
    end

    // Same line, word from the counter, word aligned
    always_comb begin
        rd_bus_addr          = rd_addr;
        rd_bus_addr.f.word   = rd_cnt;
        rd_bus_addr.f.offset = 2'b00;
    end

    assign bus.ren   = (rd_state != RD_IDLE);
    assign bus.raddr = rd_bus_addr.raw;

    // Line assembly into the port being served
    always_ff @(posedge clk_i) begin
        if (bus.rvalid) begin
            if (rd_state == RD_DATA) begin
                data_rdata_o[32*rd_cnt +: 32] <= bus.rdata;
            end else if (rd_state == RD_INST) begin
                inst_rdata_o[32*rd_cnt +: 32] <= bus.rdata;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_rvalid_o <= 1'b0;
            inst_rvalid_o <= 1'b0;
        end else begin
            data_rvalid_o <= rd_done && (rd_state == RD_DATA);
            inst_rvalid_o <= rd_done && (rd_state == RD_INST);
        end
    end

    //////////////////////////////
    // Write channel
    //////////////////////////////

    assign wr_done = (wr_state == WR_BUSY) && bus.wresp && (wr_cnt == LAST_WORD);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state <= WR_IDLE;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    wr_cnt <= '0;
                    if (wr_req) begin
                        wr_state <= WR_BUSY;
                    end
                end
                default: begin
                    if (bus.wresp) begin
                        wr_cnt <= wr_cnt + 3'd1;
                        if (wr_cnt == LAST_WORD) begin
                            wr_state <= WR_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Address and line taken once at acceptance
    always_ff @(posedge clk_i) begin
        if (wr_state == WR_IDLE && wr_req) begin
            wr_addr.raw <= data_awaddr_i;
            wr_line     <= data_wdata_i;
        end
    end

    always_comb begin
        wr_bus_addr          = wr_addr;
        wr_bus_addr.f.word   = wr_cnt;
        wr_bus_addr.f.offset = 2'b00;
    end

    assign bus.wvalid = (wr_state == WR_BUSY);
    assign bus.waddr  = wr_bus_addr.raw;
    assign bus.wdata  = wr_line[32*wr_cnt +: 32];          // Outgoing word
    assign bus.wlast  = (wr_state == WR_BUSY) && (wr_cnt == LAST_WORD);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_bvalid_o <= 1'b0;
        end else begin
            data_bvalid_o <= wr_done;
        end
    end

endmodule

// ==== src/burst_mem.sv ====
`timescale 1ns/10ps
`include "cache_bus_consts.svh"

module burst_mem
    import cache_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    word_bus_if.slave  bus
);

    localparam int IDX_W  = $clog2(`CB_MEM_WORDS);
    localparam int PACE_W = $clog2(`CB_RESP_GAP + 1);
    localparam logic [PACE_W-1:0] GAP = PACE_W'(`CB_RESP_GAP);

    logic [31:0] mem [`CB_MEM_WORDS];

    line_addr_u        ra;
    line_addr_u        wa;
    logic [IDX_W-1:0]  r_idx;
    logic [IDX_W-1:0]  w_idx;
    logic [PACE_W-1:0] r_pace;      // Gap cycles left before next read word
    logic [PACE_W-1:0] w_pace;
    logic              r_fire;
    logic              w_fire;

    // Word index from the line and word fields, byte offset dropped
    function automatic logic [IDX_W-1:0] word_index(input line_addr_u a);
        logic [29:0] word_addr;
        word_addr = {a.f.line, a.f.word};
        return word_addr[IDX_W-1:0];
    endfunction

    assign ra    = bus.raddr;
    assign wa    = bus.waddr;
    assign r_idx = word_index(ra);
    assign w_idx = word_index(wa);

    assign r_fire = bus.ren && (r_pace == '0);
    assign w_fire = bus.wvalid && (w_pace == '0);

    //////////////////////////////
    // Read pacer
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            r_pace     <= '0;
            bus.rvalid <= 1'b0;
        end else if (!bus.ren) begin
            r_pace     <= '0;           // Burst over
            bus.rvalid <= 1'b0;
        end else if (r_pace == '0) begin
            r_pace     <= GAP;
            bus.rvalid <= 1'b1;
        end else begin
            r_pace     <= r_pace - 1'b1;
            bus.rvalid <= 1'b0;
        end
    end

    // Old value wins on a same-word read and write
    always_ff @(posedge clk_i) begin
        if (r_fire) begin
            bus.rdata <= mem[r_idx];
        end
    end

    //////////////////////////////
    // Write pacer
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            w_pace    <= '0;
            bus.wresp <= 1'b0;
        end else if (!bus.wvalid) begin
            w_pace    <= '0;
            bus.wresp <= 1'b0;
        end else if (w_pace == '0) begin
            w_pace    <= GAP;
            bus.wresp <= 1'b1;          // Word stored at this edge
        end else begin
            w_pace    <= w_pace - 1'b1;
            bus.wresp <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_fire) begin
            mem[w_idx] <= bus.wdata;
        end
    end

endmodule

// ==== src/mem_subsys.sv ====
`timescale 1ns/10ps

module mem_subsys
    import cache_bus_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // Instruction cache read port
    input  logic        inst_ren_i,
    input  logic [31:0] inst_araddr_i,
    output logic        inst_rvalid_o,
    output line_t       inst_rdata_o,

    // Data cache read port
    input  logic        data_ren_i,
    input  logic [31:0] data_araddr_i,
    output logic        data_rvalid_o,
    output line_t       data_rdata_o,

    // Data cache write port
    input  logic        data_wen_i,
    input  logic [31:0] data_awaddr_i,
    input  line_t       data_wdata_i,
    output logic        data_bvalid_o
);

    // Word burst bus between bridge and memory
    word_bus_if bus ();

    cache_axi u_bridge (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .inst_ren_i    (inst_ren_i),
        .inst_araddr_i (inst_araddr_i),
        .inst_rvalid_o (inst_rvalid_o),
        .inst_rdata_o  (inst_rdata_o),
        .data_ren_i    (data_ren_i),
        .data_araddr_i (data_araddr_i),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .data_wen_i    (data_wen_i),
        .data_awaddr_i (data_awaddr_i),
        .data_wdata_i  (data_wdata_i),
        .data_bvalid_o (data_bvalid_o),
        .bus           (bus.master)
    );

    // Stands in for the external bus slave
    burst_mem u_mem (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (bus.slave)
    );

endmodule

// ==== verification/mem_subsys_props.sv ====
`timescale 1ns/10ps
`include "cache_bus_consts.svh"

module mem_subsys_props (
    input logic clk_i,
    input logic rst_i,
    input logic inst_ren_i,
    input logic inst_rvalid_i,
    input logic data_ren_i,
    input logic data_rvalid_i,
    input logic data_wen_i,
    input logic data_bvalid_i,
    input logic bus_ren_i,
    input logic bus_rvalid_i,
    input logic bus_wvalid_i,
    input logic bus_wlast_i,
    input logic bus_wresp_i
);

    int unsigned fails = 0;
    logic [3:0]  r_seen;    // Words returned in the current read burst
    logic [3:0]  w_seen;

    always_ff @(posedge clk_i) begin
        if (rst_i || !bus_ren_i) begin
            r_seen <= '0;
        end else if (bus_rvalid_i) begin
            r_seen <= r_seen + 4'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !bus_wvalid_i) begin
            w_seen <= '0;
        end else if (bus_wresp_i) begin
            w_seen <= w_seen + 4'd1;
        end
    end

    //////////////////////////////
    // Return pulses
    //////////////////////////////

    inst_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(inst_rvalid_i) |-> inst_ren_i ##1 !inst_rvalid_i)
        else begin
            $error("inst_rvalid_o wider than one cycle or without request");
            fails++;
        end
    data_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(data_rvalid_i) |-> data_ren_i ##1 !data_rvalid_i)
        else begin
            $error("data_rvalid_o wider than one cycle or without request");
            fails++;
        end
    write_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(data_bvalid_i) |-> data_wen_i ##1 !data_bvalid_i)
        else begin
            $error("data_bvalid_o wider than one cycle or without request");
            fails++;
        end

    // Bursts run to the eighth word
    ren_held: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(bus_ren_i) |-> r_seen == `CB_WORDS_PER_LINE)
        else begin
            $error("bus ren fell before the eighth word");
            fails++;
        end
    wvalid_held: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(bus_wvalid_i) |-> w_seen == `CB_WORDS_PER_LINE)
        else begin
            $error("bus wvalid fell before the eighth word");
            fails++;
        end

    // Last flag only on the eighth write word
    wlast_eighth: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_wvalid_i |-> bus_wlast_i == (w_seen == `CB_WORDS_PER_LINE - 1))
        else begin
            $error("bus wlast does not mark the eighth write word");
            fails++;
        end

endmodule

// ==== verification/tb_mem_subsys.sv ====
`timescale 1ns/10ps
`include "cache_bus_consts.svh"

module tb_mem_subsys
    import cache_bus_pkg::*;
();

    localparam logic [2:0] OP_WRITE = 3'd0;    // Data cache writeback
    localparam logic [2:0] OP_DREAD = 3'd1;
    localparam logic [2:0] OP_IREAD = 3'd2;
    localparam logic [2:0] OP_DUAL  = 3'd3;    // Data and instruction read together
    localparam logic [2:0] OP_WR_RD = 3'd4;    // Write with a parallel data read
    localparam int NUM_ENTRIES = 16;
    localparam int NUM_LINES   = 8;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 60 + 100;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [2:0]  line_idx;
        logic        alter;     // Move the held address after acceptance
    } entry_t;

    logic        clk;
    logic        rst;
    logic        inst_ren, data_ren, data_wen;
    logic [31:0] inst_araddr, data_araddr, data_awaddr;
    logic        inst_rvalid, data_rvalid, data_bvalid;
    line_t       inst_rdata, data_rdata, data_wdata;

    entry_t      entries [NUM_ENTRIES];
    line_t       ref_lines [NUM_LINES];
    int          model_line [128];      // Reference line held at each memory line
    int          mismatch_errs = 0;
    int          proto_errs = 0;
    int          cycle_cnt;

    mem_subsys u_dut (
        .clk_i (clk), .rst_i (rst),
        .inst_ren_i (inst_ren), .inst_araddr_i (inst_araddr),
        .inst_rvalid_o (inst_rvalid), .inst_rdata_o (inst_rdata),
        .data_ren_i (data_ren), .data_araddr_i (data_araddr),
        .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata),
        .data_wen_i (data_wen), .data_awaddr_i (data_awaddr),
        .data_wdata_i (data_wdata), .data_bvalid_o (data_bvalid)
    );

    bind mem_subsys mem_subsys_props u_props (
        .clk_i (clk_i), .rst_i (rst_i),
        .inst_ren_i (inst_ren_i), .inst_rvalid_i (inst_rvalid_o),
        .data_ren_i (data_ren_i), .data_rvalid_i (data_rvalid_o),
        .data_wen_i (data_wen_i), .data_bvalid_i (data_bvalid_o),
        .bus_ren_i (bus.ren), .bus_rvalid_i (bus.rvalid),
        .bus_wvalid_i (bus.wvalid), .bus_wlast_i (bus.wlast), .bus_wresp_i (bus.wresp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 1024 words of memory make 128 lines of 32 bytes
    function automatic logic [6:0] line_key(input logic [31:0] addr);
        return addr[11:5];
    endfunction

    function automatic line_t expected_line(input logic [31:0] addr);
        if (model_line[line_key(addr)] < 0) begin
            return 'x;
        end
        return ref_lines[model_line[line_key(addr)]];
    endfunction

    task automatic fill_lines();
        logic [31:0] seed;
        seed = 32'h1807_9d85;
        for (int i = 0; i < NUM_LINES; i++) begin
            for (int k = 0; k < `CB_WORDS_PER_LINE; k++) begin
                seed = xorshift32(seed);
                ref_lines[i][32*k +: 32] = seed;
            end
        end
    endtask

    task automatic load_table();
        entries[0]  = '{OP_WRITE, 32'h0000_0200, 32'h0,         3'd0, 1'b0};
        entries[1]  = '{OP_DREAD, 32'h0000_0200, 32'h0,         3'd0, 1'b0};
        entries[2]  = '{OP_WRITE, 32'h0000_0460, 32'h0,         3'd1, 1'b0};
        entries[3]  = '{OP_IREAD, 32'h0000_0200, 32'h0,         3'd0, 1'b0};
        entries[4]  = '{OP_IREAD, 32'h0000_047b, 32'h0,         3'd0, 1'b0}; // Odd offset
        entries[5]  = '{OP_WRITE, 32'h0000_0a40, 32'h0,         3'd2, 1'b0};
        entries[6]  = '{OP_DUAL,  32'h0000_0460, 32'h0000_0a40, 3'd0, 1'b0};
        entries[7]  = '{OP_WR_RD, 32'h0000_0c00, 32'h0000_0200, 3'd3, 1'b0};
        entries[8]  = '{OP_DREAD, 32'h0000_0c00, 32'h0,         3'd0, 1'b0};
        entries[9]  = '{OP_WRITE, 32'h0000_0e20, 32'h0,         3'd4, 1'b1};
        entries[10] = '{OP_DREAD, 32'h0000_0e20, 32'h0,         3'd0, 1'b1};
        entries[11] = '{OP_IREAD, 32'h0000_0a40, 32'h0,         3'd0, 1'b1};
        entries[12] = '{OP_DUAL,  32'h0000_0200, 32'h0000_0c00, 3'd0, 1'b0};
        entries[13] = '{OP_WR_RD, 32'h0000_0200, 32'h0000_0460, 3'd5, 1'b1};
        entries[14] = '{OP_DREAD, 32'h0000_0200, 32'h0,         3'd0, 1'b0};
        entries[15] = '{OP_DUAL,  32'h0000_0e20, 32'h0000_0200, 3'd0, 1'b0};
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic note_pulse(input string name, input logic pulse, input logic wanted,
                              input int n, inout logic got, inout int at);
        if (pulse) begin
            assert (wanted && !got) else begin
                $display("return pulse on %s that no pending request asked for", name);
                proto_errs++;
            end
            if (wanted) begin
                got = 1'b1;
                at  = n;
            end
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!inst_rvalid && !data_rvalid && !data_bvalid) else begin
                $display("return pulse while no request was pending");
                proto_errs++;
            end
        end
    endtask

    //////////////////////////////
    // One table entry
    //////////////////////////////

    task automatic run_entry(input entry_t e);
        logic  want_d, want_i, want_w;
        logic  got_d, got_i, got_w;
        int    at_d, at_i, at_w;
        int    n;
        logic  done;
        line_t exp_d, exp_i;

        want_w = (e.op == OP_WRITE) || (e.op == OP_WR_RD);
        want_d = (e.op == OP_DREAD) || (e.op == OP_DUAL) || (e.op == OP_WR_RD);
        want_i = (e.op == OP_IREAD) || (e.op == OP_DUAL);
        data_wen    = want_w;
        data_awaddr = e.addr_a;
        data_wdata  = ref_lines[e.line_idx];
        data_ren    = want_d;
        data_araddr = (e.op == OP_WR_RD) ? e.addr_b : e.addr_a;
        inst_ren    = want_i;
        inst_araddr = (e.op == OP_DUAL) ? e.addr_b : e.addr_a;
        exp_d = expected_line(data_araddr);     // Model sees the address at request time
        exp_i = expected_line(inst_araddr);
        {got_d, got_i, got_w} = 3'b000;
        {at_d, at_i, at_w} = {32'd0, 32'd0, 32'd0};
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            n++;
            // Request falls one cycle after its return
            if (got_d) begin
                data_ren = 1'b0;
            end
            if (got_i) begin
                inst_ren = 1'b0;
            end
            if (got_w) begin
                data_wen = 1'b0;
            end
            if (e.alter && n == 1) begin
                data_araddr = data_araddr ^ 32'h20;     // Neighbouring line
                data_awaddr = data_awaddr ^ 32'h20;
                data_wdata  = ~data_wdata;
                if (!want_d) begin
                    inst_araddr = inst_araddr ^ 32'h20;
                end
            end
            note_pulse("data_rvalid_o", data_rvalid, want_d, n, got_d, at_d);
            note_pulse("inst_rvalid_o", inst_rvalid, want_i, n, got_i, at_i);
            note_pulse("data_bvalid_o", data_bvalid, want_w, n, got_w, at_w);
            done = (got_d == want_d) && (got_i == want_i) && (got_w == want_w) &&
                   !data_ren && !inst_ren && !data_wen;
        end
        if (want_d) begin
            check_line("data_rdata_o", data_rdata, exp_d);
        end
        if (want_i) begin
            check_line("inst_rdata_o", inst_rdata, exp_i);
        end
        if (want_d && want_i) begin
            assert (at_d < at_i) else begin
                $display("data cache return did not come before the instruction return");
                proto_errs++;
            end
        end
        if (want_w) begin
            model_line[line_key(e.addr_a)] = e.line_idx;
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, a return pulse never came", cycle_cnt);
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b1;
        {inst_ren, data_ren, data_wen} = 3'b000;
        {inst_araddr, data_araddr, data_awaddr} = '0;
        data_wdata = '0;
        fill_lines();
        load_table();
        foreach (model_line[i]) begin
            model_line[i] = -1;     // Nothing written yet
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_quiet(10);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(entries[i]);
        end
        check_quiet(10);
        total = mismatch_errs + proto_errs + int'(u_dut.u_props.fails);
        $display("errors: %0d mismatch, %0d protocol, %0d assertion",
                 mismatch_errs, proto_errs, u_dut.u_props.fails);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+src
src/cache_bus_pkg.sv
src/word_bus_if.sv
src/cache_axi.sv
src/burst_mem.sv
src/mem_subsys.sv
verification/mem_subsys_props.sv
verification/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - src

sources:
  # RTL
  - include_dirs:
      - src
    files:
      - src/cache_bus_pkg.sv
      - src/word_bus_if.sv
      - src/cache_axi.sv
      - src/burst_mem.sv
      - src/mem_subsys.sv
  # Testbench
  - target: test
    include_dirs:
      - src
    files:
      - verification/mem_subsys_props.sv
      - verification/tb_mem_subsys.sv
